// ==== build.f ====
logic/retro_pkg.sv
logic/byte_lane_counter.sv
logic/register_file.sv
logic/instr_decoder.sv
logic/alu_branch.sv
logic/fetch_sequencer.sv
logic/retro_core.sv
dv/store_checker.sv
dv/retro_tb.sv

// ==== Bender.yml ====
package:
  name: retro_core

sources:
  - logic/retro_pkg.sv
  - logic/byte_lane_counter.sv
  - logic/register_file.sv
  - logic/instr_decoder.sv
  - logic/alu_branch.sv
  - logic/fetch_sequencer.sv
  - logic/retro_core.sv
  - target: simulation
    files:
      - dv/store_checker.sv
      - dv/retro_tb.sv

// ==== dv/retro_tb.sv ====
`default_nettype none

module retro_tb;

  typedef enum int {
    t_lui, t_addi, t_slti, t_sltiu, t_xori, t_ori, t_andi, t_slli, t_srli, t_srai,
    t_add, t_sub, t_slt, t_sltu, t_xor, t_or, t_and, t_sll, t_srl, t_sra,
    t_beq, t_bne, t_blt, t_bge, t_bltu, t_bgeu, t_jal, t_x0
  } tb_op_t;

  localparam int mem_size     = 4096;
  localparam int store_base   = 16'h0600;  // below 2048 so SW can use x0 as base
  localparam int row_budget   = 400;       // worst-case cycles per table row
  localparam logic [31:0] poison = 32'hDEADBEEF;

  logic             clk = 1'b0;
  logic             reset = 1'b1;
  logic             mem_ack = 1'b0;
  retro_pkg::byte_t mem_rdata = '0;
  retro_pkg::addr_t mem_addr;
  retro_pkg::byte_t mem_wdata;
  logic             mem_req;
  logic             mem_we;

  retro_pkg::byte_t mem [mem_size];
  logic [15:0]      lfsr_state = 16'd43424;
  tb_op_t           row_op [64];
  logic [31:0]      row_a [64];
  logic [31:0]      row_b [64];
  int               n_rows = 0;
  int               n_expected = 0;
  int               wp = 0;  // program write pointer
  logic             built = 1'b0;

  always #4 clk = ~clk;

  retro_core dut0 (
    .clk(clk), .reset(reset), .mem_addr(mem_addr), .mem_req(mem_req), .mem_we(mem_we),
    .mem_wdata(mem_wdata), .mem_ack(mem_ack), .mem_rdata(mem_rdata)
  );

  store_checker chk0 (
    .clk(clk), .reset(reset), .mem_addr(mem_addr), .mem_req(mem_req), .mem_we(mem_we),
    .mem_wdata(mem_wdata), .mem_ack(mem_ack)
  );

  function logic lfsr_step();
    logic lsb;
    lsb = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (lsb) lfsr_state = lfsr_state ^ 16'hB400;
    return lsb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) v = {v[30:0], lfsr_step()};
    return v;
  endfunction

  function automatic logic [2:0] funct3_of(input tb_op_t op);
    case (op)
      t_slli, t_sll, t_bne:           return 3'd1;
      t_slti, t_slt:                  return 3'd2;
      t_sltiu, t_sltu:                return 3'd3;
      t_xori, t_xor, t_blt:           return 3'd4;
      t_srli, t_srai, t_srl, t_sra, t_bge: return 3'd5;
      t_ori, t_or, t_bltu:            return 3'd6;
      t_andi, t_and, t_bgeu:          return 3'd7;
      default:                        return 3'd0;
    endcase
  endfunction

  // expected result from the RV32I definitions
  function automatic logic [31:0] ref_alu(input tb_op_t op, input logic [31:0] a,
                                          input logic [31:0] b);
    case (op)
      t_lui:          return {a[31:12], 12'b0};
      t_addi, t_add:  return a + b;
      t_sub:          return a - b;
      t_slti, t_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      t_sltiu, t_sltu: return (a < b) ? 32'd1 : 32'd0;
      t_xori, t_xor:  return a ^ b;
      t_ori, t_or:    return a | b;
      t_andi, t_and:  return a & b;
      t_slli, t_sll:  return a << b[4:0];
      t_srli, t_srl:  return a >> b[4:0];
      default:        return $unsigned($signed(a) >>> b[4:0]);
    endcase
  endfunction

  function automatic logic ref_taken(input tb_op_t op, input logic [31:0] a,
                                     input logic [31:0] b);
    case (op)
      t_beq:   return a == b;
      t_bne:   return a != b;
      t_blt:   return $signed(a) < $signed(b);
      t_bge:   return $signed(a) >= $signed(b);
      t_bltu:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, retro_pkg::opc_op_imm};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], retro_pkg::opc_store};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], retro_pkg::opc_branch};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, retro_pkg::opc_jal};
  endfunction

  task automatic emit(input logic [31:0] instr);
    for (int k = 0; k < 4; k++) mem[wp + k] = instr[8 * k +: 8];
    wp += 4;
  endtask

  task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] upper;
    upper = (v + 32'h800) >> 12;  // compensates the addi sign extension
    emit({upper[19:0], rd, retro_pkg::opc_lui});
    emit(enc_i(v[11:0], rd, 3'd0, rd));
  endtask

  task automatic add_row(input tb_op_t op, input logic [31:0] a, input logic [31:0] b);
    row_op[n_rows] = op;
    row_a[n_rows]  = a;
    row_b[n_rows]  = b;
    n_rows++;
  endtask

  task automatic expect_word(input int addr, input logic [31:0] data);
    chk0.expect_store(retro_pkg::addr_t'(addr), data);
    n_expected++;
  endtask

  task automatic build_table();
    for (int op = t_lui; op <= t_sra; op++) begin
      if (op >= t_slli && op <= t_srai) add_row(tb_op_t'(op), rand_bits(32), rand_bits(5));
      else if (op <= t_andi) add_row(tb_op_t'(op), rand_bits(32), rand_bits(12));
      else add_row(tb_op_t'(op), rand_bits(32), rand_bits(32));
    end
    for (int r = 1; r <= 6; r++) row_b[r] = {{20{row_b[r][11]}}, row_b[r][11:0]};
    add_row(t_sra, 32'h8000_1234, 32'd37);  // shift amount masked to 5
    add_row(t_srai, 32'hF000_0000, 32'd31);
    add_row(t_sll, 32'h0000_00FF, 32'd40);
    add_row(t_srl, 32'h8000_0000, 32'd63);
    add_row(t_slti, 32'hFFFF_FFF0, 32'hFFFF_FFF8);
    add_row(t_beq, 5, 5);
    add_row(t_beq, 5, 6);
    add_row(t_bne, 5, 6);
    add_row(t_bne, 5, 5);
    add_row(t_blt, -3, 2);
    add_row(t_blt, 2, -3);
    add_row(t_bge, 2, -3);
    add_row(t_bge, -3, 2);
    add_row(t_bltu, 2, -3);
    add_row(t_bltu, -3, 2);
    add_row(t_bgeu, -3, 2);
    add_row(t_bgeu, 2, -3);
    add_row(t_jal, 0, 0);
    add_row(t_x0, 0, 0);
  endtask

  task automatic build_program();
    int          slot;
    int          jal_addr;
    logic [11:0] imm;
    logic [6:0]  f7;
    tb_op_t      op;
    for (int i = 0; i < mem_size; i++) begin
      mem[i] = retro_pkg::byte_t'(i ^ (i >> 8));  // address pattern around the program
    end
    load_const(5, poison);
    for (int r = 0; r < n_rows; r++) begin
      op   = row_op[r];
      slot = store_base + 4 * r;
      if (op == t_jal) begin
        jal_addr = wp;
        emit(enc_j(21'd8, 5'd6));
        emit(enc_s(slot[11:0], 5'd5, 5'd0));  // skipped
        emit(enc_s(slot[11:0], 5'd6, 5'd0));
        expect_word(slot, jal_addr + 4);
      end else if (op == t_x0) begin
        emit(enc_i(12'h123, 5'd0, 3'd0, 5'd0));
        emit(enc_s(slot[11:0], 5'd0, 5'd0));
        expect_word(slot, 32'd0);
      end else begin
        load_const(1, row_a[r]);
        load_const(2, row_b[r]);
        if (op >= t_beq) begin
          emit(enc_b(13'd8, 5'd2, 5'd1, funct3_of(op)));
          emit(enc_s(slot[11:0], 5'd5, 5'd0));  // poison when not skipped
          if (!ref_taken(op, row_a[r], row_b[r])) expect_word(slot, poison);
        end else begin
          if (op == t_lui) begin
            emit({row_a[r][31:12], 5'd3, retro_pkg::opc_lui});
          end else if (op <= t_srai) begin
            imm = (op == t_srai) ? {7'h20, row_b[r][4:0]} : row_b[r][11:0];
            emit(enc_i(imm, 5'd1, funct3_of(op), 5'd3));
          end else begin
            f7 = (op == t_sub || op == t_sra) ? 7'h20 : 7'h00;
            emit({f7, 5'd2, 5'd1, funct3_of(op), 5'd3, retro_pkg::opc_op});
          end
          emit(enc_s(slot[11:0], 5'd3, 5'd0));
          expect_word(slot, ref_alu(op, row_a[r], row_b[r]));
        end
      end
    end
    emit(enc_j(21'd0, 5'd0));  // park on itself
  endtask

  // byte memory, answers each request after 0 to 3 extra cycles
  initial begin : memory_model
    int delay;
    forever begin
      @(posedge clk);
      #1;
      if (!reset && mem_req && !mem_ack) begin
        delay = int'(rand_bits(2));
        repeat (delay) begin
          @(posedge clk);
          #1;
        end
        if (mem_we) mem[mem_addr % mem_size] = mem_wdata;
        else mem_rdata = mem[mem_addr % mem_size];
        mem_ack = 1'b1;
        while (mem_req) begin
          @(posedge clk);
          #1;
        end
        mem_ack = 1'b0;
      end
    end
  end

  initial begin : watchdog
    wait (built);
    #((n_rows + 2) * row_budget * 8);
    $display("watchdog expired with %0d of %0d words stored", chk0.words_seen, n_expected);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin : main
    int errors;
    build_table();
    build_program();
    built = 1'b1;
    repeat (16) @(posedge clk);
    #1 reset = 1'b0;
    while (chk0.words_seen < n_expected) @(posedge clk);
    repeat (200) @(posedge clk);  // catch stray writes after the last word
    errors = chk0.data_errors + chk0.protocol_errors;
    $display("errors %0d (data %0d, protocol %0d), words %0d of %0d", errors,
             chk0.data_errors, chk0.protocol_errors, chk0.words_seen, n_expected);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/store_checker.sv ====
`default_nettype none

module store_checker (
  input  wire logic             clk,
  input  wire logic             reset,
  input  wire retro_pkg::addr_t mem_addr,
  input  wire logic             mem_req,
  input  wire logic             mem_we,
  input  wire retro_pkg::byte_t mem_wdata,
  input  wire logic             mem_ack
);

  retro_pkg::addr_t exp_addr [$];
  retro_pkg::word_t exp_data [$];
  int               data_errors = 0;
  int               protocol_errors = 0;
  int               words_seen = 0;
  logic             req_q = 1'b0;
  logic             ack_q = 1'b0;
  logic             reset_q = 1'b1;
  logic             seen_first = 1'b0;
  int               nbytes = 0;
  retro_pkg::addr_t base;
  retro_pkg::word_t word;

  task automatic expect_store(input retro_pkg::addr_t addr, input retro_pkg::word_t data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  task automatic compare_word();
    retro_pkg::addr_t a;
    retro_pkg::word_t d;
    if (exp_addr.size() == 0) begin
      $display("unexpected store of %h at address %h, time %0t", word, base, $time);
      data_errors++;
    end else begin
      a = exp_addr.pop_front();
      d = exp_data.pop_front();
      if (base !== a) begin
        $display("[ERROR] %0t store_addr: got %h expected %h", $time, base, a);
        data_errors++;
      end
      if (word !== d) begin
        $display("[ERROR] %0t store_word: got %h expected %h", $time, word, d);
        data_errors++;
      end
    end
  endtask

  always @(posedge clk) begin
    if (!reset) begin
      if (reset_q && (mem_req !== 1'b0 || mem_we !== 1'b0)) begin
        $display("request or write enable not low right after reset, time %0t", $time);
        protocol_errors++;
      end
      if (!seen_first && mem_we) begin
        $display("write enable high before the first fetch, time %0t", $time);
        protocol_errors++;
      end
      if (!seen_first && mem_req) begin
        seen_first = 1'b1;
        if (mem_addr !== retro_pkg::reset_pc) begin
          $display("[ERROR] %0t mem_addr: got %h expected %h", $time, mem_addr,
                   retro_pkg::reset_pc);
          protocol_errors++;
        end
      end
      if (mem_req && !req_q && ack_q) begin  // ack as seen on the edge that raised req
        $display("request raised while ack was still high, time %0t", $time);
        protocol_errors++;
      end
      if (mem_req && mem_ack && mem_we) begin  // one sampled edge per byte
        if (nbytes == 0) begin
          base = mem_addr;
        end else if (mem_addr !== base + retro_pkg::addr_t'(nbytes)) begin
          $display("store byte %0d at %h is not next to base %h, time %0t",
                   nbytes, mem_addr, base, $time);
          protocol_errors++;
        end
        word[8 * nbytes +: 8] = mem_wdata;  // least significant byte first
        nbytes++;
        if (nbytes == 4) begin
          compare_word();
          nbytes = 0;
          words_seen++;
        end
      end
    end
    req_q   = mem_req;
    ack_q   = mem_ack;
    reset_q = reset;
  end

endmodule

`default_nettype wire

// ==== logic/retro_core.sv ====
`default_nettype none

module retro_core (
  input  logic             clk,
  input  logic             reset,
  output retro_pkg::addr_t mem_addr,
  output logic             mem_req,
  output logic             mem_we,
  output retro_pkg::byte_t mem_wdata,
  input  logic             mem_ack,
  input  retro_pkg::byte_t mem_rdata
);

  logic                 byte_load;
  logic                 lane_step;
  logic                 lane_clear;
  logic                 operand_load;
  logic                 reg_write;
  logic                 pc_update;
  logic                 store_active;
  logic                 taken;
  logic                 last_lane;
  logic [2:0]           funct_branch;
  retro_pkg::lane_t     lane;
  retro_pkg::op_class_t op_class;
  retro_pkg::alu_op_t   alu_op;
  retro_pkg::reg_id_t   rd;
  retro_pkg::reg_id_t   rs1;
  retro_pkg::reg_id_t   rs2;
  retro_pkg::word_t     imm;
  retro_pkg::word_t     rdata1;
  retro_pkg::word_t     rdata2;
  retro_pkg::word_t     result;
  retro_pkg::word_t     wb_data;
  retro_pkg::addr_t     pc;
  retro_pkg::addr_t     next_pc;
  retro_pkg::addr_t     store_addr;
  retro_pkg::word_t     store_word;

  fetch_sequencer seq0 (
    .clk          (clk),
    .reset        (reset),
    .op_class     (op_class),
    .taken        (taken),
    .last_lane    (last_lane),
    .mem_ack      (mem_ack),
    .mem_req      (mem_req),
    .mem_we       (mem_we),
    .byte_load    (byte_load),
    .lane_step    (lane_step),
    .lane_clear   (lane_clear),
    .operand_load (operand_load),
    .reg_write    (reg_write),
    .pc_update    (pc_update),
    .store_active (store_active)
  );

  byte_lane_counter lane0 (
    .clk       (clk),
    .reset     (reset),
    .step      (lane_step),
    .clear     (lane_clear),
    .lane      (lane),
    .last_lane (last_lane)
  );

  instr_decoder dec0 (
    .clk          (clk),
    .reset        (reset),
    .byte_load    (byte_load),
    .lane         (lane),
    .fetch_byte   (mem_rdata),
    .op_class     (op_class),
    .alu_op       (alu_op),
    .funct_branch (funct_branch),
    .rd           (rd),
    .rs1          (rs1),
    .rs2          (rs2),
    .imm          (imm)
  );

  register_file rf0 (
    .clk      (clk),
    .reset    (reset),
    .write_en (reg_write),
    .read_en  (operand_load),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .wdata    (wb_data),
    .rdata1   (rdata1),
    .rdata2   (rdata2)
  );

  alu_branch alu0 (
    .alu_op       (alu_op),
    .op_class     (op_class),
    .funct_branch (funct_branch),
    .a            (rdata1),
    .b            (rdata2),
    .imm          (imm),
    .result       (result),
    .taken        (taken)
  );

  // jal links the address after itself
  assign wb_data = (op_class == retro_pkg::class_jal) ?
                   retro_pkg::word_t'(pc) + 32'd4 : result;

  assign next_pc = (op_class == retro_pkg::class_jal || taken) ?
                   pc + imm[15:0] : pc + 16'd4;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= retro_pkg::reset_pc;
    end else if (pc_update) begin
      pc <= next_pc;
    end
  end

  // rs1 + imm and rs2 latch as the execute cycle ends, then hold during the store
  always_ff @(posedge clk) begin
    if (!store_active) begin
      store_addr <= result[15:0];
      store_word <= rdata2;
    end
  end

  assign mem_addr  = store_active ? store_addr + retro_pkg::addr_t'(lane) :
                                    pc + retro_pkg::addr_t'(lane);
  assign mem_wdata = store_word[8 * lane +: 8];  // least significant byte first

endmodule

`default_nettype wire

// ==== logic/fetch_sequencer.sv ====
`default_nettype none

module fetch_sequencer (
  input  logic                 clk,
  input  logic                 reset,
  input  retro_pkg::op_class_t op_class,
  input  logic                 taken,
  input  logic                 last_lane,
  input  logic                 mem_ack,
  output logic                 mem_req,
  output logic                 mem_we,
  output logic                 byte_load,
  output logic                 lane_step,
  output logic                 lane_clear,
  output logic                 operand_load,
  output logic                 reg_write,
  output logic                 pc_update,
  output logic                 store_active
);

  retro_pkg::seq_state_t state;
  retro_pkg::seq_state_t state_next;

  // req and we are flops so they stay clean on the bus
  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= retro_pkg::st_fetch_req;
      mem_req <= 1'b0;
      mem_we  <= 1'b0;
    end else begin
      state   <= state_next;
      mem_req <= (state_next == retro_pkg::st_fetch_req) ||
                 (state_next == retro_pkg::st_store_req);
      mem_we  <= (state_next == retro_pkg::st_store_req);
    end
  end

  assign store_active = (state == retro_pkg::st_store_req) ||
                        (state == retro_pkg::st_store_wait);

  always_comb begin
    state_next   = state;
    byte_load    = 1'b0;
    lane_step    = 1'b0;
    lane_clear   = 1'b0;
    operand_load = 1'b0;
    reg_write    = 1'b0;
    pc_update    = 1'b0;
    case (state)
      retro_pkg::st_fetch_req: begin
        if (mem_ack) begin
          byte_load  = 1'b1;  // rdata valid while ack is high
          state_next = retro_pkg::st_fetch_wait;
        end
      end
      retro_pkg::st_fetch_wait: begin
        if (!mem_ack) begin
          if (last_lane) begin
            lane_clear = 1'b1;
            state_next = retro_pkg::st_decode;
          end else begin
            lane_step  = 1'b1;
            state_next = retro_pkg::st_fetch_req;
          end
        end
      end
      retro_pkg::st_decode: begin
        operand_load = 1'b1;
        state_next   = retro_pkg::st_execute;
      end
      retro_pkg::st_execute: begin
        case (op_class)
          retro_pkg::class_alu_imm, retro_pkg::class_alu_reg,
          retro_pkg::class_lui, retro_pkg::class_jal: begin
            reg_write  = 1'b1;
            pc_update  = 1'b1;
            state_next = retro_pkg::st_fetch_req;
          end
          retro_pkg::class_store: begin
            state_next = retro_pkg::st_store_req;  // pc moves after the last byte
          end
          retro_pkg::class_branch: begin
            pc_update  = 1'b1;  // target or fall through picked in the core
            state_next = retro_pkg::st_fetch_req;
          end
          default: begin
            pc_update  = 1'b1;
            state_next = retro_pkg::st_fetch_req;
          end
        endcase
      end
      retro_pkg::st_store_req: begin
        if (mem_ack) begin
          state_next = retro_pkg::st_store_wait;
        end
      end
      retro_pkg::st_store_wait: begin
        if (!mem_ack) begin
          if (last_lane) begin
            lane_clear = 1'b1;
            pc_update  = 1'b1;
            state_next = retro_pkg::st_fetch_req;
          end else begin
            lane_step  = 1'b1;
            state_next = retro_pkg::st_store_req;
          end
        end
      end
      default: begin
        state_next = retro_pkg::st_fetch_req;
      end
    endcase
  end

  // four-phase rule, req is raised only on an edge where ack was already low
  assert property (@(posedge clk) disable iff (reset) $rose(mem_req) |-> !$past(mem_ack));

  assert property (@(posedge clk) disable iff (reset) !(reg_write && store_active));

endmodule

`default_nettype wire

// ==== logic/alu_branch.sv ====
`default_nettype none

module alu_branch (
  input  retro_pkg::alu_op_t   alu_op,
  input  retro_pkg::op_class_t op_class,
  input  logic [2:0]           funct_branch,
  input  retro_pkg::word_t     a,
  input  retro_pkg::word_t     b,
  input  retro_pkg::word_t     imm,
  output retro_pkg::word_t     result,
  output logic                 taken
);

  retro_pkg::word_t operand;
  logic [4:0]       shamt;
  logic             equal;
  logic             less;
  logic             less_u;
  logic             cond;

  assign operand = (op_class == retro_pkg::class_alu_reg) ? b : imm;
  assign shamt   = operand[4:0];  // higher shift bits ignored

  always_comb begin
    case (alu_op)
      retro_pkg::alu_add:  result = a + operand;
      retro_pkg::alu_sub:  result = a - operand;
      retro_pkg::alu_slt:  result = {31'b0, $signed(a) < $signed(operand)};
      retro_pkg::alu_sltu: result = {31'b0, a < operand};
      retro_pkg::alu_xor:  result = a ^ operand;
      retro_pkg::alu_or:   result = a | operand;
      retro_pkg::alu_and:  result = a & operand;
      retro_pkg::alu_sll:  result = a << shamt;
      retro_pkg::alu_srl:  result = a >> shamt;
      retro_pkg::alu_sra:  result = $signed(a) >>> shamt;
      default:             result = a + operand;
    endcase
    if (op_class == retro_pkg::class_lui) begin
      result = imm;  // upper immediate passes straight
    end
  end

  // branches always compare the two registers
  assign equal  = (a == b);
  assign less   = ($signed(a) < $signed(b));
  assign less_u = (a < b);

  always_comb begin
    case (funct_branch)
      3'b000:  cond = equal;    // beq
      3'b001:  cond = !equal;   // bne
      3'b100:  cond = less;     // blt
      3'b101:  cond = !less;    // bge
      3'b110:  cond = less_u;   // bltu
      3'b111:  cond = !less_u;  // bgeu
      default: cond = 1'b0;
    endcase
  end

  assign taken = (op_class == retro_pkg::class_branch) && cond;

endmodule

`default_nettype wire

// ==== logic/instr_decoder.sv ====
`default_nettype none

module instr_decoder (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 byte_load,
  input  retro_pkg::lane_t     lane,
  input  retro_pkg::byte_t     fetch_byte,
  output retro_pkg::op_class_t op_class,
  output retro_pkg::alu_op_t   alu_op,
  output logic [2:0]           funct_branch,
  output retro_pkg::reg_id_t   rd,
  output retro_pkg::reg_id_t   rs1,
  output retro_pkg::reg_id_t   rs2,
  output retro_pkg::word_t     imm
);

  retro_pkg::word_t instr;
  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic             funct7_bit;  // selects sub and sra

  always_ff @(posedge clk) begin
    if (reset) begin
      instr <= '0;  // opcode zero decodes as nop
    end else if (byte_load) begin
      instr[8 * lane +: 8] <= fetch_byte;  // little endian fill
    end
  end

  assign opcode       = instr[6:0];
  assign funct3       = instr[14:12];
  assign funct7_bit   = instr[30];
  assign rd           = instr[11:7];
  assign rs1          = instr[19:15];
  assign rs2          = instr[24:20];
  assign funct_branch = funct3;

  always_comb begin
    op_class = retro_pkg::class_nop;
    imm      = '0;
    case (opcode)
      retro_pkg::opc_lui: begin
        op_class = retro_pkg::class_lui;
        imm      = {instr[31:12], 12'b0};
      end
      retro_pkg::opc_op_imm: begin
        op_class = retro_pkg::class_alu_imm;
        imm      = {{20{instr[31]}}, instr[31:20]};  // shamt sits in bits 4:0
      end
      retro_pkg::opc_op: begin
        op_class = retro_pkg::class_alu_reg;
      end
      retro_pkg::opc_branch: begin
        op_class = retro_pkg::class_branch;
        imm      = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      retro_pkg::opc_jal: begin
        op_class = retro_pkg::class_jal;
        imm      = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      retro_pkg::opc_store: begin
        op_class = retro_pkg::class_store;
        imm      = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      end
      default: begin
        op_class = retro_pkg::class_nop;  // anything else does nothing
      end
    endcase
  end

  // same funct3 map for immediate and register forms
  always_comb begin
    alu_op = retro_pkg::alu_add;  // also the store address add
    if (op_class == retro_pkg::class_alu_imm || op_class == retro_pkg::class_alu_reg) begin
      case (funct3)
        3'b000: begin
          alu_op = (op_class == retro_pkg::class_alu_reg && funct7_bit) ?
                   retro_pkg::alu_sub : retro_pkg::alu_add;
        end
        3'b001:  alu_op = retro_pkg::alu_sll;
        3'b010:  alu_op = retro_pkg::alu_slt;
        3'b011:  alu_op = retro_pkg::alu_sltu;
        3'b100:  alu_op = retro_pkg::alu_xor;
        3'b101:  alu_op = funct7_bit ? retro_pkg::alu_sra : retro_pkg::alu_srl;
        3'b110:  alu_op = retro_pkg::alu_or;
        default: alu_op = retro_pkg::alu_and;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/register_file.sv ====
`default_nettype none

module register_file (
  input  logic               clk,
  input  logic               reset,
  input  logic               write_en,
  input  logic               read_en,
  input  retro_pkg::reg_id_t rs1,
  input  retro_pkg::reg_id_t rs2,
  input  retro_pkg::reg_id_t rd,
  input  retro_pkg::word_t   wdata,
  output retro_pkg::word_t   rdata1,
  output retro_pkg::word_t   rdata2
);

  retro_pkg::word_t regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      regs[0] <= '0;  // x0 starts at zero
    end else if (write_en && rd != '0) begin
      regs[rd] <= wdata;  // x0 stays unwritten
    end
  end

  // registered read of both ports
  always_ff @(posedge clk) begin
    if (reset) begin
      rdata1 <= '0;
      rdata2 <= '0;
    end else if (read_en) begin
      rdata1 <= regs[rs1];
      rdata2 <= regs[rs2];
    end
  end

  // x0 reads zero only if every write to it was dropped
  assert property (@(posedge clk) disable iff (reset)
    read_en && rs1 == '0 |=> rdata1 == '0);
  assert property (@(posedge clk) disable iff (reset)
    read_en && rs2 == '0 |=> rdata2 == '0);

endmodule

`default_nettype wire

// ==== logic/byte_lane_counter.sv ====
`default_nettype none

module byte_lane_counter (
  input  logic             clk,
  input  logic             reset,
  input  logic             step,
  input  logic             clear,
  output retro_pkg::lane_t lane,
  output logic             last_lane
);

  always_ff @(posedge clk) begin
    if (reset) begin
      lane <= '0;
    end else if (clear) begin
      lane <= '0;
    end else if (step) begin
      lane <= lane + 2'd1;  // one completed transfer
    end
  end

  assign last_lane = (lane == 2'd3);

  // the sequencer either advances or restarts the word, never both
  assert property (@(posedge clk) disable iff (reset) !(step && clear));

endmodule

`default_nettype wire

// ==== logic/retro_pkg.sv ====
`default_nettype none

package retro_pkg;

  typedef logic [15:0] addr_t;  // external byte address
  typedef logic [31:0] word_t;  // register and data word
  typedef logic [7:0]  byte_t;  // bus data
  typedef logic [4:0]  reg_id_t;
  typedef logic [1:0]  lane_t;  // byte within a word

  // execution class picked by the decoder
  typedef enum logic [2:0] {
    class_alu_imm,
    class_alu_reg,
    class_lui,
    class_branch,
    class_jal,
    class_store,
    class_nop
  } op_class_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_or,
    alu_and,
    alu_sll,
    alu_srl,
    alu_sra
  } alu_op_t;

  typedef enum logic [2:0] {
    st_fetch_req,   // request one instruction byte
    st_fetch_wait,  // wait for ack to drop
    st_decode,      // read register operands
    st_execute,
    st_store_req,   // request one store byte
    st_store_wait
  } seq_state_t;

  localparam addr_t reset_pc = 16'h0000;

  // major opcodes kept from RV32I
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_store  = 7'b0100011;

endpackage

`default_nettype wire
